//--- logic/mipsIsaPkg.sv
// instruction-set constants for the single-cycle MIPS core
// data and address widths, instruction field positions,
// opcodes, R-type function codes and the link register number

package mipsIsaPkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int wordBits     = 32;
  localparam int regAddrBits  = 5;
  localparam int regCount     = 32;
  localparam int dataAddrBits = 7;
  localparam int opBits       = 6;
  localparam int functBits    = 6;
  localparam int immBits      = 16;
  localparam int indexBits    = 26;

  // lsb of each instruction field
  localparam int opLsb    = 26;
  localparam int rsLsb    = 21;
  localparam int rtLsb    = 16;
  localparam int rdLsb    = 11;
  localparam int functLsb = 0;

  // ==========================================================================
  // opcodes
  // ==========================================================================
  localparam logic [opBits-1:0] opRtype = 6'b000000;
  localparam logic [opBits-1:0] opJ     = 6'b000010;
  localparam logic [opBits-1:0] opJal   = 6'b000011;
  localparam logic [opBits-1:0] opBeq   = 6'b000100;
  localparam logic [opBits-1:0] opAddi  = 6'b001000;
  localparam logic [opBits-1:0] opLw    = 6'b100011;
  localparam logic [opBits-1:0] opSw    = 6'b101011;

  // R-type function field
  localparam logic [functBits-1:0] fnJr  = 6'b001000;
  localparam logic [functBits-1:0] fnAdd = 6'b100000;
  localparam logic [functBits-1:0] fnSub = 6'b100010;
  localparam logic [functBits-1:0] fnAnd = 6'b100100;
  localparam logic [functBits-1:0] fnOr  = 6'b100101;
  localparam logic [functBits-1:0] fnSlt = 6'b101010;

  // jal return address goes here
  localparam logic [regAddrBits-1:0] regLink = 5'd31;

endpackage

//--- logic/mipsCtrlPkg.sv
// control definitions for the single-cycle MIPS core
// decoder ALU request, ALU operation encoding
// and the packed control word passed from decode onwards

package mipsCtrlPkg;

  // ==========================================================================
  // ALU request from the main decoder
  // ==========================================================================
  typedef enum logic [1:0] {
    memAdd    = 2'b00,
    branchSub = 2'b01,
    rtypeFunc = 2'b10,
    immAdd    = 2'b11
  } aluOp_t;

  // ALU operation, classic MIPS textbook encoding
  typedef enum logic [3:0] {
    aluAnd  = 4'b0000,
    aluOr   = 4'b0001,
    aluAdd  = 4'b0010,
    aluSub  = 4'b0110,
    aluSlt  = 4'b0111,
    aluNone = 4'b1111
  } aluCtrl_t;

  // ==========================================================================
  // control word
  // ==========================================================================
  // all zero means no write anywhere, pc+4 next
  typedef struct packed {
    logic   regDst;
    logic   aluSrc;
    logic   memToReg;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   jump;
    logic   branch;
    logic   link;
    logic   jumpReg;
    aluOp_t aluOp;
  } ctrlWord_t;

endpackage

//--- logic/decodeBus.sv
// decode to execute/fetch bus
// carries the control word, register operands,
// extended immediate, function field and jump index

interface decodeBus;

  // control for the current instruction
  mipsCtrlPkg::ctrlWord_t ctrl;

  // register operands, driven from the register file read ports
  logic [mipsIsaPkg::wordBits-1:0] rsData;
  logic [mipsIsaPkg::wordBits-1:0] rtData;

  // sign-extended 16-bit immediate
  logic [mipsIsaPkg::wordBits-1:0] immExt;

  // R-type function field
  logic [mipsIsaPkg::functBits-1:0] funct;

  // instruction index already shifted left by two
  logic [mipsIsaPkg::indexBits+1:0] jumpTarget;

  modport decoder (
    output ctrl,
    output immExt,
    output funct,
    output jumpTarget
  );

  modport execute (
    input ctrl,
    input rsData,
    input rtData,
    input immExt,
    input funct
  );

  // next-address selection only
  modport fetch (
    input ctrl,
    input rsData,
    input immExt,
    input jumpTarget
  );

endinterface

//--- logic/fetchUnit.sv
// fetch stage of the single-cycle MIPS core
// program counter register and next-address selection
// priority is jump, taken branch, jr, then pc+4

module fetchUnit (
  input  logic                            clk,
  input  logic                            rst,
  decodeBus.fetch                         bus,
  input  logic                            branchTaken,
  output logic [mipsIsaPkg::wordBits-1:0] pc,
  output logic [mipsIsaPkg::wordBits-1:0] pcPlus4
);

  import mipsIsaPkg::*;

  logic [wordBits-1:0] branchAddr;
  logic [wordBits-1:0] jumpAddr;
  logic [wordBits-1:0] nextPc;

  // sequential address
  assign pcPlus4 = pc + 32'd4;

  // branch offset counts words
  assign branchAddr = pcPlus4 + {bus.immExt[wordBits-3:0], 2'b00};

  // j/jal stay within the current 256 MB region
  assign jumpAddr = {pcPlus4[wordBits-1:wordBits-4], bus.jumpTarget};

  // ==========================================================================
  // next-address select
  // ==========================================================================
  always_comb begin
    if (bus.ctrl.jump) begin
      nextPc = jumpAddr;
    end else if (branchTaken) begin
      nextPc = branchAddr;
    end else if (bus.ctrl.jumpReg) begin
      // jr takes rs as is
      nextPc = bus.rsData;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc register, starts at address 0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- logic/decodeUnit.sv
// decode stage of the single-cycle MIPS core
// main control decoding, immediate sign extension,
// jump index forming and destination register select

module decodeUnit (
  input  logic [mipsIsaPkg::wordBits-1:0]    instr,
  decodeBus.decoder                          bus,
  output logic [mipsIsaPkg::regAddrBits-1:0] rsAddr,
  output logic [mipsIsaPkg::regAddrBits-1:0] rtAddr,
  output logic [mipsIsaPkg::regAddrBits-1:0] writeAddr
);

  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  logic [opBits-1:0]      opcode;
  logic [functBits-1:0]   funct;
  logic [regAddrBits-1:0] rdAddr;
  logic [immBits-1:0]     imm;
  ctrlWord_t              ctrl;

  // ==========================================================================
  // field split
  // ==========================================================================
  assign opcode = instr[opLsb +: opBits];
  assign funct  = instr[functLsb +: functBits];
  assign rsAddr = instr[rsLsb +: regAddrBits];
  assign rtAddr = instr[rtLsb +: regAddrBits];
  assign rdAddr = instr[rdLsb +: regAddrBits];
  assign imm    = instr[immBits-1:0];

  // ==========================================================================
  // main control
  // ==========================================================================
  always_comb begin
    // unknown opcodes fall through as a no-op
    ctrl = '0;
    case (opcode)
      opRtype: begin
        ctrl.aluOp = rtypeFunc;
        if (funct == fnJr) begin
          ctrl.jumpReg = 1'b1;
        end else begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end
      opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = immAdd;
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluOp    = memAdd;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = memAdd;
      end
      opBeq: begin
        // compare by subtraction in the ALU
        ctrl.branch = 1'b1;
        ctrl.aluOp  = branchSub;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  assign bus.ctrl  = ctrl;
  assign bus.funct = funct;

  // sign extension
  assign bus.immExt = {{(wordBits-immBits){imm[immBits-1]}}, imm};

  // index shifted to a byte address
  assign bus.jumpTarget = {instr[indexBits-1:0], 2'b00};

  // destination: r31 for jal, rd for R-type, rt otherwise
  always_comb begin
    if (ctrl.link) begin
      writeAddr = regLink;
    end else if (ctrl.regDst) begin
      writeAddr = rdAddr;
    end else begin
      writeAddr = rtAddr;
    end
  end

endmodule

//--- logic/regFile.sv
// register file of the single-cycle MIPS core
// 31 writable registers plus hard-wired zero,
// two combinational read ports and one write port

module regFile (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               writeEn,
  input  logic [mipsIsaPkg::regAddrBits-1:0] rsAddr,
  input  logic [mipsIsaPkg::regAddrBits-1:0] rtAddr,
  input  logic [mipsIsaPkg::regAddrBits-1:0] writeAddr,
  input  logic [mipsIsaPkg::wordBits-1:0]    writeData,
  output logic [mipsIsaPkg::wordBits-1:0]    rsData,
  output logic [mipsIsaPkg::wordBits-1:0]    rtData
);

  import mipsIsaPkg::*;

  // no storage behind register 0
  logic [wordBits-1:0] regs [1:regCount-1];

  // ==========================================================================
  // write port
  // ==========================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 are dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ==========================================================================
  // read ports
  // ==========================================================================
  always_comb begin
    if (rsAddr == '0) begin
      rsData = '0;
    end else begin
      rsData = regs[rsAddr];
    end
  end

  always_comb begin
    if (rtAddr == '0) begin
      rtData = '0;
    end else begin
      rtData = regs[rtAddr];
    end
  end

endmodule

//--- logic/executeUnit.sv
// execute stage of the single-cycle MIPS core
// ALU control, second-operand select,
// ALU and the beq branch decision

module executeUnit (
  decodeBus.execute                       bus,
  output logic [mipsIsaPkg::wordBits-1:0] aluResult,
  output logic                            branchTaken
);

  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  aluCtrl_t            aluCtrl;
  logic [wordBits-1:0] opA;
  logic [wordBits-1:0] opB;

  // ==========================================================================
  // ALU control
  // ==========================================================================
  always_comb begin
    case (bus.ctrl.aluOp)
      memAdd:    aluCtrl = aluAdd;
      immAdd:    aluCtrl = aluAdd;
      branchSub: aluCtrl = aluSub;
      rtypeFunc: begin
        // jr and anything unsupported land on aluNone
        case (bus.funct)
          fnAdd:   aluCtrl = aluAdd;
          fnSub:   aluCtrl = aluSub;
          fnAnd:   aluCtrl = aluAnd;
          fnOr:    aluCtrl = aluOr;
          fnSlt:   aluCtrl = aluSlt;
          default: aluCtrl = aluNone;
        endcase
      end
      default:   aluCtrl = aluNone;
    endcase
  end

  // operands
  assign opA = bus.rsData;
  assign opB = bus.ctrl.aluSrc ? bus.immExt : bus.rtData;

  // ==========================================================================
  // ALU
  // ==========================================================================
  always_comb begin
    case (aluCtrl)
      aluAdd:  aluResult = opA + opB;
      aluSub:  aluResult = opA - opB;
      aluAnd:  aluResult = opA & opB;
      aluOr:   aluResult = opA | opB;
      // signed compare
      aluSlt:  aluResult = {{(wordBits-1){1'b0}}, ($signed(opA) < $signed(opB))};
      default: aluResult = '0;
    endcase
  end

  // beq: rs - rt came out zero
  assign branchTaken = bus.ctrl.branch && (aluResult == '0);

endmodule

//--- logic/mipsCore.sv
// top level of the single-cycle MIPS core
// wires fetch, decode, register file and execute stages,
// selects the write-back value and drives the data SRAM strobes

module mipsCore (
  input  logic                                clk,
  input  logic                                rst,
  output logic [mipsIsaPkg::wordBits-1:0]     instrAddr,
  input  logic [mipsIsaPkg::wordBits-1:0]     instr,
  output logic [mipsIsaPkg::wordBits-1:0]     regWriteData,
  input  logic [mipsIsaPkg::wordBits-1:0]     memReadData,
  output logic                                memCen,
  output logic                                memWen,
  output logic [mipsIsaPkg::dataAddrBits-1:0] memAddr,
  output logic [mipsIsaPkg::wordBits-1:0]     memWriteData
);

  import mipsIsaPkg::*;

  logic [wordBits-1:0]    pc;
  logic [wordBits-1:0]    pcPlus4;
  logic [regAddrBits-1:0] rsAddr;
  logic [regAddrBits-1:0] rtAddr;
  logic [regAddrBits-1:0] writeAddr;
  logic [wordBits-1:0]    rsData;
  logic [wordBits-1:0]    rtData;
  logic [wordBits-1:0]    aluResult;
  logic                   branchTaken;
  logic [wordBits-1:0]    writeData;

  decodeBus bus ();

  // ==========================================================================
  // stages
  // ==========================================================================
  fetchUnit uFetch (
    .clk         (clk),
    .rst         (rst),
    .bus         (bus.fetch),
    .branchTaken (branchTaken),
    .pc          (pc),
    .pcPlus4     (pcPlus4)
  );

  decodeUnit uDecode (
    .instr     (instr),
    .bus       (bus.decoder),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .writeAddr (writeAddr)
  );

  regFile uRegFile (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (bus.ctrl.regWrite),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .rsData    (rsData),
    .rtData    (rtData)
  );

  // register operands onto the bus
  assign bus.rsData = rsData;
  assign bus.rtData = rtData;

  executeUnit uExecute (
    .bus         (bus.execute),
    .aluResult   (aluResult),
    .branchTaken (branchTaken)
  );

  // ==========================================================================
  // write-back and data memory
  // ==========================================================================
  // lw data, jal return address, else ALU
  always_comb begin
    if (bus.ctrl.memToReg) begin
      writeData = memReadData;
    end else if (bus.ctrl.link) begin
      writeData = pcPlus4;
    end else begin
      writeData = aluResult;
    end
  end

  assign regWriteData = writeData;
  assign instrAddr    = pc;

  // strobes active low, chip enable on lw and sw only
  assign memCen       = ~(bus.ctrl.memRead | bus.ctrl.memWrite);
  assign memWen       = ~bus.ctrl.memWrite;
  // word address from the byte sum
  assign memAddr      = aluResult[dataAddrBits+1:2];
  assign memWriteData = rtData;

endmodule

//--- test/dataSram.sv
// behavioral data SRAM for the MIPS core testbench
// 128 words, active-low chip enable and write enable,
// combinational read, write at the rising edge

module dataSram (
  input  logic                                clk,
  input  logic                                cen,
  input  logic                                wen,
  input  logic [mipsIsaPkg::dataAddrBits-1:0] addr,
  input  logic [mipsIsaPkg::wordBits-1:0]     writeData,
  output logic [mipsIsaPkg::wordBits-1:0]     readData
);

  import mipsIsaPkg::*;

  // one word per address, no reset
  logic [wordBits-1:0] mem [0:(1 << dataAddrBits)-1];

  // ==========================================================================
  // write port
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!cen && !wen) begin
      mem[addr] <= writeData;
    end
  end

  // read follows the address while the chip is enabled
  assign readData = cen ? '0 : mem[addr];

endmodule

//--- test/mipsCoreTb.sv
// testbench for the single-cycle MIPS core
// clock and reset, program ROM with a seeded random block,
// shadow ISA model and concurrent checks on the core ports

module mipsCoreTb;

  import mipsIsaPkg::*;

  localparam int romWords  = 64;
  localparam int randBase  = 26;
  localparam int randCount = 24;
  localparam int endIdx    = randBase + randCount;
  localparam int runLimit  = 400;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic [31:0] regWriteData;
  logic [31:0] memReadData;
  logic        memCen;
  logic        memWen;
  logic [6:0]  memAddr;
  logic [31:0] memWriteData;

  logic [31:0] rom [0:romWords-1];
  integer      seed;

  // shadow state
  logic [31:0] modelPc;
  logic [31:0] modelRegs [0:31];
  logic [31:0] modelMem [0:127];

  // expected values for the instruction at modelPc
  logic [31:0] modelInstr;
  logic [31:0] rsVal;
  logic [31:0] rtVal;
  logic [31:0] sext;
  logic [31:0] pc4;
  logic [31:0] sumAddr;
  logic [31:0] expWb;
  logic [31:0] expNext;
  logic [4:0]  expDest;
  logic        expWrite;
  logic        isLw;
  logic        isSw;

  mipsCore UUT (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .regWriteData (regWriteData),
    .memReadData  (memReadData),
    .memCen       (memCen),
    .memWen       (memWen),
    .memAddr      (memAddr),
    .memWriteData (memWriteData)
  );

  dataSram uSram (
    .clk       (clk),
    .cen       (memCen),
    .wen       (memWen),
    .addr      (memAddr),
    .writeData (memWriteData),
    .readData  (memReadData)
  );

  // program ROM, word addressed
  assign instr = rom[instrAddr[7:2]];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================================
  // instruction encoders
  // ==========================================================================
  function automatic logic [31:0] rtypeWord(input logic [5:0] fn, input logic [4:0] rs,
      input logic [4:0] rt, input logic [4:0] rd);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itypeWord(input logic [5:0] op, input logic [4:0] rs,
      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jtypeWord(input logic [5:0] op, input logic [25:0] index);
    return {op, index};
  endfunction

  task automatic buildProgram();
    logic [31:0] r;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    // unused words jump to themselves
    for (int i = 0; i < romWords; i++) begin
      rom[i] = jtypeWord(opJ, 26'(i));
    end
    rom[0]  = itypeWord(opAddi, 5'd0, 5'd1, 16'd5);
    rom[1]  = itypeWord(opAddi, 5'd0, 5'd2, 16'hfffd);
    rom[2]  = rtypeWord(fnAdd, 5'd1, 5'd2, 5'd3);
    rom[3]  = rtypeWord(fnSub, 5'd2, 5'd1, 5'd4);
    rom[4]  = rtypeWord(fnAnd, 5'd1, 5'd2, 5'd5);
    rom[5]  = rtypeWord(fnOr, 5'd1, 5'd2, 5'd6);
    // signed compare, -3 < 5
    rom[6]  = rtypeWord(fnSlt, 5'd2, 5'd1, 5'd7);
    rom[7]  = rtypeWord(fnSlt, 5'd1, 5'd2, 5'd8);
    // r0 must stay zero
    rom[8]  = itypeWord(opAddi, 5'd1, 5'd0, 16'd7);
    rom[9]  = rtypeWord(fnAdd, 5'd0, 5'd1, 5'd9);
    rom[10] = itypeWord(opAddi, 5'd0, 5'd10, 16'h0040);
    rom[11] = itypeWord(opSw, 5'd10, 5'd4, 16'd8);
    rom[12] = itypeWord(opSw, 5'd10, 5'd2, 16'hfffc);
    rom[13] = itypeWord(opLw, 5'd10, 5'd11, 16'd8);
    rom[14] = itypeWord(opLw, 5'd10, 5'd12, 16'hfffc);
    // taken forward skips word 16, then not taken
    rom[15] = itypeWord(opBeq, 5'd1, 5'd9, 16'd1);
    rom[16] = itypeWord(opAddi, 5'd0, 5'd13, 16'd99);
    rom[17] = itypeWord(opBeq, 5'd1, 5'd2, 16'd5);
    rom[18] = jtypeWord(opJal, 26'd22);
    rom[19] = jtypeWord(opJ, 26'(randBase));
    // subroutine, backward beq taken once
    rom[22] = itypeWord(opAddi, 5'd15, 5'd15, 16'd1);
    rom[23] = itypeWord(opAddi, 5'd0, 5'd16, 16'd1);
    rom[24] = itypeWord(opBeq, 5'd15, 5'd16, 16'hfffd);
    rom[25] = rtypeWord(fnJr, regLink, 5'd0, 5'd0);
    // random block on r0..r15
    for (int i = 0; i < randCount; i++) begin
      r  = $random(seed);
      rs = {1'b0, r[3:0]};
      rt = {1'b0, r[7:4]};
      rd = {1'b0, r[11:8]};
      case (r[14:12])
        3'd0:    rom[randBase+i] = rtypeWord(fnAdd, rs, rt, rd);
        3'd1:    rom[randBase+i] = rtypeWord(fnSub, rs, rt, rd);
        3'd2:    rom[randBase+i] = rtypeWord(fnAnd, rs, rt, rd);
        3'd3:    rom[randBase+i] = rtypeWord(fnOr, rs, rt, rd);
        3'd4:    rom[randBase+i] = rtypeWord(fnSlt, rs, rt, rd);
        default: rom[randBase+i] = itypeWord(opAddi, rs, rd, r[31:16]);
      endcase
    end
    rom[endIdx] = jtypeWord(opJ, 26'(endIdx));
  endtask

  // ==========================================================================
  // shadow ISA model
  // ==========================================================================
  always_comb begin
    modelInstr = rom[modelPc[7:2]];
    rsVal      = modelRegs[modelInstr[25:21]];
    rtVal      = modelRegs[modelInstr[20:16]];
    sext       = {{16{modelInstr[15]}}, modelInstr[15:0]};
    pc4        = modelPc + 32'd4;
    sumAddr    = rsVal + sext;
    expWrite   = 1'b0;
    expWb      = '0;
    expDest    = modelInstr[20:16];
    expNext    = pc4;
    isLw       = 1'b0;
    isSw       = 1'b0;
    case (modelInstr[31:26])
      opRtype: begin
        expDest  = modelInstr[15:11];
        expWrite = 1'b1;
        case (modelInstr[5:0])
          fnAdd: expWb = rsVal + rtVal;
          fnSub: expWb = rsVal - rtVal;
          fnAnd: expWb = rsVal & rtVal;
          fnOr:  expWb = rsVal | rtVal;
          fnSlt: expWb = {31'd0, $signed(rsVal) < $signed(rtVal)};
          fnJr: begin
            expWrite = 1'b0;
            expNext  = rsVal;
          end
          default: expWrite = 1'b0;
        endcase
      end
      opAddi: begin
        expWrite = 1'b1;
        expWb    = sumAddr;
      end
      opLw: begin
        isLw     = 1'b1;
        expWrite = 1'b1;
        expWb    = modelMem[sumAddr[8:2]];
      end
      opSw: isSw = 1'b1;
      opBeq: begin
        if (rsVal == rtVal) begin
          expNext = pc4 + {sext[29:0], 2'b00};
        end
      end
      opJ: expNext = {pc4[31:28], modelInstr[25:0], 2'b00};
      opJal: begin
        expWrite = 1'b1;
        expDest  = regLink;
        expWb    = pc4;
        expNext  = {pc4[31:28], modelInstr[25:0], 2'b00};
      end
      default: begin
      end
    endcase
  end

  // model state moves on the same edge as the core
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      modelPc <= '0;
      for (int i = 0; i < 32; i++) begin
        modelRegs[i] <= '0;
      end
      for (int i = 0; i < 128; i++) begin
        modelMem[i] <= '0;
      end
    end else begin
      modelPc <= expNext;
      if (expWrite && expDest != 5'd0) begin
        modelRegs[expDest] <= expWb;
      end
      if (isSw) begin
        modelMem[sumAddr[8:2]] <= rtVal;
      end
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  task automatic reportMismatch(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    $display("[FAIL] time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    $display(">>> FAIL");
    $fatal(1, "mismatch on %s", name);
  endtask

  pcCheck: assert property (@(posedge clk) disable iff (!rst) instrAddr == modelPc)
    else reportMismatch("instrAddr", $sampled(modelPc), $sampled(instrAddr));

  cenCheck: assert property (@(posedge clk) disable iff (!rst) memCen == !(isLw || isSw))
    else reportMismatch("memCen", {31'd0, $sampled(!(isLw || isSw))}, {31'd0, $sampled(memCen)});

  wenCheck: assert property (@(posedge clk) disable iff (!rst) memWen == !isSw)
    else reportMismatch("memWen", {31'd0, $sampled(!isSw)}, {31'd0, $sampled(memWen)});

  addrCheck: assert property (@(posedge clk) disable iff (!rst)
      (isLw || isSw) |-> memAddr == sumAddr[8:2])
    else reportMismatch("memAddr", {25'd0, $sampled(sumAddr[8:2])}, {25'd0, $sampled(memAddr)});

  wdataCheck: assert property (@(posedge clk) disable iff (!rst)
      isSw |-> memWriteData == rtVal)
    else reportMismatch("memWriteData", $sampled(rtVal), $sampled(memWriteData));

  wbCheck: assert property (@(posedge clk) disable iff (!rst)
      expWrite |-> regWriteData == expWb)
    else reportMismatch("regWriteData", $sampled(expWb), $sampled(regWriteData));

  // ==========================================================================
  // run control
  // ==========================================================================
  initial begin
    int cycles;
    rst  <= 1'b0;
    seed = 32'h598d;
    buildProgram();
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    // poll at the falling edge, where the pc is settled
    cycles = 0;
    @(negedge clk);
    while (instrAddr !== 32'(endIdx * 4) && cycles < runLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (instrAddr === 32'(endIdx * 4)) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("timeout: program did not reach its final self-jump in %0d cycles", runLimit);
      $display(">>> FAIL");
      $fatal(1, "run timed out");
    end
  end

endmodule

//--- mipsCore.f
logic/mipsIsaPkg.sv
logic/mipsCtrlPkg.sv
logic/decodeBus.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/mipsCore.sv
test/dataSram.sv
test/mipsCoreTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# builds the MIPS core testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mipsCoreTb \
  -Mdir obj_dir \
  -f mipsCore.f

# the simulator exits nonzero on a failed check, the search below decides
simOut="$(./obj_dir/VmipsCoreTb 2>&1)" || true
echo "$simOut"

if grep -qx '>>> PASS' <<< "$simOut"; then
  exit 0
else
  exit 1
fi
